//--- verilog/csi2_config.svh
`ifndef CSI2_CONFIG_SVH
`define CSI2_CONFIG_SVH

// CSR bus widths
`define CSI2_CSR_ADDR_W 8
`define CSI2_DATA_W     32

// Video stream payload
`define CSI2_PX_W       16

// Lane delay taps
`define CSI2_DELAY_W    5
`define CSI2_LANES      2

// Camera power-up delay in px_clk cycles, kept short for simulation
`define CSI2_PWUP_CYCLES 64

`endif

//--- verilog/csi2_pkg.sv
`default_nettype none

`include "csi2_config.svh"

package csi2_pkg;

  // Manager to register block
  typedef struct packed {
    logic                          awvalid;
    logic [`CSI2_CSR_ADDR_W-1 : 0] awaddr;
    logic                          wvalid;
    logic [`CSI2_DATA_W-1 : 0]     wdata;
    logic [3 : 0]                  wstrb;
    logic                          bready;
    logic                          arvalid;
    logic [`CSI2_CSR_ADDR_W-1 : 0] araddr;
    logic                          rready;
  } axil_req_t;

  // Register block to manager
  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    logic [1 : 0]              bresp;
    logic                      arready;
    logic                      rvalid;
    logic [`CSI2_DATA_W-1 : 0] rdata;
    logic [1 : 0]              rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic                    tvalid;
    logic                    tuser;
    logic                    tlast;
    logic [`CSI2_PX_W-1 : 0] tdata;
  } video_t;

  // One-cycle pulses from the packet decoder
  typedef struct packed {
    logic header_err;
    logic corr_header_err;
    logic crc_err;
  } csi2_err_t;

  typedef struct packed {
    logic [`CSI2_DATA_W-1 : 0] header_err_cnt;
    logic [`CSI2_DATA_W-1 : 0] corr_header_err_cnt;
    logic [`CSI2_DATA_W-1 : 0] crc_err_cnt;
    logic [`CSI2_DATA_W-1 : 0] max_ln_per_frame;
    logic [`CSI2_DATA_W-1 : 0] min_ln_per_frame;
    logic [`CSI2_DATA_W-1 : 0] max_px_per_ln;
    logic [`CSI2_DATA_W-1 : 0] min_px_per_ln;
  } csi2_stat_t;

  // Register map, byte addresses
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_CTRL             = 8'h00;
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_SCCB_ADDR        = 8'h04;
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_DELAY            = 8'h08;
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_HDR_ERR_CNT      = 8'h10;
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_CORR_HDR_ERR_CNT = 8'h14;
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_CRC_ERR_CNT      = 8'h18;
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_MAX_LN_PER_FRAME = 8'h1C;
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_MIN_LN_PER_FRAME = 8'h20;
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_MAX_PX_PER_LN    = 8'h24;
  localparam logic [`CSI2_CSR_ADDR_W-1 : 0] REG_MIN_PX_PER_LN    = 8'h28;

  localparam logic [1 : 0] RESP_OKAY   = 2'b00;
  localparam logic [1 : 0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- verilog/csi2_stat_acc.sv
`timescale 1ns/1ps
`default_nettype none

`include "csi2_config.svh"

module csi2_stat_acc (
  input  logic                 px_clk_i,
  input  logic                 reset_i,
  input  logic                 clear_stat_i,
  input  csi2_pkg::video_t     video_i,
  input  logic                 tready_i,
  input  csi2_pkg::csi2_err_t  err_i,
  output csi2_pkg::csi2_stat_t stat_o
);

  import csi2_pkg::*;

  logic                      beat;
  logic                      line_end;
  logic                      frame_start;
  logic [`CSI2_DATA_W-1 : 0] line_len;

  logic [`CSI2_DATA_W-1 : 0] header_err_cnt;
  logic [`CSI2_DATA_W-1 : 0] corr_header_err_cnt;
  logic [`CSI2_DATA_W-1 : 0] crc_err_cnt;

  logic [`CSI2_DATA_W-1 : 0] px_cnt;
  logic [`CSI2_DATA_W-1 : 0] max_px_per_ln;
  logic [`CSI2_DATA_W-1 : 0] min_px_per_ln;

  logic [`CSI2_DATA_W-1 : 0] ln_cnt;
  logic                      frame_seen;
  logic [`CSI2_DATA_W-1 : 0] max_ln_per_frame;
  logic [`CSI2_DATA_W-1 : 0] min_ln_per_frame;

  // Only accepted beats count
  assign beat        = video_i.tvalid && tready_i;
  assign line_end    = beat && video_i.tlast;
  assign frame_start = beat && video_i.tuser;

  // Length including the closing beat
  assign line_len    = px_cnt + 1'b1;

  always_ff @(posedge px_clk_i) begin
    if (reset_i || clear_stat_i) begin
      header_err_cnt      <= '0;
      corr_header_err_cnt <= '0;
      crc_err_cnt         <= '0;
    end else begin
      if (err_i.header_err)
        header_err_cnt <= header_err_cnt + 1'b1;
      if (err_i.corr_header_err)
        corr_header_err_cnt <= corr_header_err_cnt + 1'b1;
      if (err_i.crc_err)
        crc_err_cnt <= crc_err_cnt + 1'b1;
    end
  end

  // Pixels per line
  always_ff @(posedge px_clk_i) begin
    if (reset_i || clear_stat_i) begin
      px_cnt        <= '0;
      max_px_per_ln <= '0;
      min_px_per_ln <= '1;
    end else if (line_end) begin
      px_cnt <= '0;
      if (line_len > max_px_per_ln)
        max_px_per_ln <= line_len;
      if (line_len < min_px_per_ln)
        min_px_per_ln <= line_len;
    end else if (beat) begin
      px_cnt <= px_cnt + 1'b1;
    end
  end

  // Lines per frame, a frame closes on the next tuser
  always_ff @(posedge px_clk_i) begin
    if (reset_i || clear_stat_i) begin
      ln_cnt           <= '0;
      frame_seen       <= 1'b0;
      max_ln_per_frame <= '0;
      min_ln_per_frame <= '1;
    end else if (frame_start) begin
      // tuser beat may also end a one-beat line
      ln_cnt     <= `CSI2_DATA_W'(video_i.tlast);
      frame_seen <= 1'b1;
      if (frame_seen) begin
        if (ln_cnt > max_ln_per_frame)
          max_ln_per_frame <= ln_cnt;
        if (ln_cnt < min_ln_per_frame)
          min_ln_per_frame <= ln_cnt;
      end
    end else if (line_end) begin
      ln_cnt <= ln_cnt + 1'b1;
    end
  end

  always_comb begin
    stat_o.header_err_cnt      = header_err_cnt;
    stat_o.corr_header_err_cnt = corr_header_err_cnt;
    stat_o.crc_err_cnt         = crc_err_cnt;
    stat_o.max_ln_per_frame    = max_ln_per_frame;
    stat_o.min_ln_per_frame    = min_ln_per_frame;
    stat_o.max_px_per_ln       = max_px_per_ln;
    stat_o.min_px_per_ln       = min_px_per_ln;
  end

endmodule

`default_nettype wire

//--- verilog/csi2_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "csi2_config.svh"

module csi2_csr (
  input  logic                                          px_clk_i,
  input  logic                                          reset_i,
  input  csi2_pkg::axil_req_t                           req_i,
  output csi2_pkg::axil_rsp_t                           rsp_o,
  input  csi2_pkg::csi2_stat_t                          stat_i,
  output logic                                          clear_stat_o,
  output logic                                          phy_en_o,
  output logic                                          delay_act_o,
  output logic [`CSI2_LANES-1 : 0][`CSI2_DELAY_W-1 : 0] lane_delay_o,
  output logic [6 : 0]                                  sccb_slave_addr_o
);

  import csi2_pkg::*;

  logic                                          awready_q;
  logic                                          bvalid_q;
  logic [1 : 0]                                  bresp_q;
  logic                                          arready_q;
  logic                                          rvalid_q;
  logic [`CSI2_DATA_W-1 : 0]                     rdata_q;
  logic [1 : 0]                                  rresp_q;

  logic                                          wr_en;
  logic                                          wr_err;
  logic                                          rd_en;
  logic                                          rd_err;
  logic [`CSI2_DATA_W-1 : 0]                     rd_data;

  logic                                          phy_en_q;
  logic                                          clear_stat_q;
  logic                                          delay_act_q;
  logic [`CSI2_LANES-1 : 0][`CSI2_DELAY_W-1 : 0] lane_delay_q;
  logic [6 : 0]                                  sccb_addr_q;

  assign wr_en = awready_q && req_i.awvalid && req_i.wvalid;
  assign rd_en = arready_q && req_i.arvalid;

  // Only the control registers are writable
  always_comb begin
    case (req_i.awaddr)
      REG_CTRL, REG_SCCB_ADDR, REG_DELAY: wr_err = 1'b0;
      default:                            wr_err = 1'b1;
    endcase
  end

  // Write channel, address and data accepted together
  always_ff @(posedge px_clk_i) begin
    if (reset_i) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      awready_q <= req_i.awvalid && req_i.wvalid && !awready_q && !bvalid_q;
      if (wr_en)
        bvalid_q <= 1'b1;
      else if (req_i.bready)
        bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge px_clk_i) begin
    if (wr_en)
      bresp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
  end

  always_ff @(posedge px_clk_i) begin
    if (reset_i) begin
      phy_en_q     <= 1'b0;
      clear_stat_q <= 1'b0;
      delay_act_q  <= 1'b0;
      lane_delay_q <= '0;
      sccb_addr_q  <= '0;
    end else begin
      // Self-clearing pulses
      clear_stat_q <= 1'b0;
      delay_act_q  <= 1'b0;
      if (wr_en) begin
        case (req_i.awaddr)
          REG_CTRL: begin
            if (req_i.wstrb[0]) begin
              phy_en_q     <= req_i.wdata[0];
              clear_stat_q <= req_i.wdata[1];
              delay_act_q  <= req_i.wdata[2];
            end
          end
          REG_SCCB_ADDR: begin
            if (req_i.wstrb[0])
              sccb_addr_q <= req_i.wdata[6 : 0];
          end
          REG_DELAY: begin
            // One byte lane per data lane
            for (int i = 0; i < `CSI2_LANES; i++) begin
              if (req_i.wstrb[i])
                lane_delay_q[i] <= req_i.wdata[8*i +: `CSI2_DELAY_W];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Read mux, pulse bits read back as zero
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (req_i.araddr)
      REG_CTRL:             rd_data[0] = phy_en_q;
      REG_SCCB_ADDR:        rd_data[6 : 0] = sccb_addr_q;
      REG_DELAY: begin
        for (int i = 0; i < `CSI2_LANES; i++)
          rd_data[8*i +: `CSI2_DELAY_W] = lane_delay_q[i];
      end
      REG_HDR_ERR_CNT:      rd_data = stat_i.header_err_cnt;
      REG_CORR_HDR_ERR_CNT: rd_data = stat_i.corr_header_err_cnt;
      REG_CRC_ERR_CNT:      rd_data = stat_i.crc_err_cnt;
      REG_MAX_LN_PER_FRAME: rd_data = stat_i.max_ln_per_frame;
      REG_MIN_LN_PER_FRAME: rd_data = stat_i.min_ln_per_frame;
      REG_MAX_PX_PER_LN:    rd_data = stat_i.max_px_per_ln;
      REG_MIN_PX_PER_LN:    rd_data = stat_i.min_px_per_ln;
      default:              rd_err = 1'b1;
    endcase
  end

  // Read channel
  always_ff @(posedge px_clk_i) begin
    if (reset_i) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      arready_q <= req_i.arvalid && !arready_q && !rvalid_q;
      if (rd_en)
        rvalid_q <= 1'b1;
      else if (req_i.rready)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge px_clk_i) begin
    if (rd_en) begin
      rdata_q <= rd_data;
      rresp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  always_comb begin
    rsp_o.awready = awready_q;
    rsp_o.wready  = awready_q;
    rsp_o.bvalid  = bvalid_q;
    rsp_o.bresp   = bresp_q;
    rsp_o.arready = arready_q;
    rsp_o.rvalid  = rvalid_q;
    rsp_o.rdata   = rdata_q;
    rsp_o.rresp   = rresp_q;
  end

  assign clear_stat_o      = clear_stat_q;
  assign phy_en_o          = phy_en_q;
  assign delay_act_o       = delay_act_q;
  assign lane_delay_o      = lane_delay_q;
  assign sccb_slave_addr_o = sccb_addr_q;

endmodule

`default_nettype wire

//--- verilog/cam_pwup.sv
`timescale 1ns/1ps
`default_nettype none

`include "csi2_config.svh"

module cam_pwup (
  input  logic px_clk_i,
  input  logic reset_i,
  output logic cam_pwup_o
);

  localparam int unsigned CNT_W     = $clog2(`CSI2_PWUP_CYCLES);
  localparam int unsigned PWUP_LAST = `CSI2_PWUP_CYCLES - 1;

  logic [CNT_W-1 : 0] cnt;
  logic               pwup_q;

  // Counter stops once the output is set
  always_ff @(posedge px_clk_i) begin
    if (reset_i) begin
      cnt    <= '0;
      pwup_q <= 1'b0;
    end else if (!pwup_q) begin
      if (cnt == PWUP_LAST[CNT_W-1 : 0])
        pwup_q <= 1'b1;
      else
        cnt <= cnt + 1'b1;
    end
  end

  assign cam_pwup_o = pwup_q;

endmodule

`default_nettype wire

//--- verilog/csi2_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csi2_config.svh"

module csi2_monitor_top (
  input  logic                                          px_clk_i,
  input  logic                                          reset_i,

  // Register access
  input  csi2_pkg::axil_req_t                           csr_req_i,
  output csi2_pkg::axil_rsp_t                           csr_rsp_o,

  // Video from the receiver
  input  csi2_pkg::video_t                              video_up_i,
  output logic                                          up_tready_o,

  // Video to the sink
  output csi2_pkg::video_t                              video_o,
  input  logic                                          video_tready_i,

  // Packet decoder error pulses
  input  csi2_pkg::csi2_err_t                           err_i,

  // Receiver and SCCB controls
  output logic                                          phy_en_o,
  output logic                                          delay_act_o,
  output logic [`CSI2_LANES-1 : 0][`CSI2_DELAY_W-1 : 0] lane_delay_o,
  output logic [6 : 0]                                  sccb_slave_addr_o,

  output logic                                          cam_pwup_o
);

  import csi2_pkg::*;

  logic       clear_stat;
  csi2_stat_t stat;

  // Stream is only tapped, never delayed
  assign video_o     = video_up_i;
  assign up_tready_o = video_tready_i;

  csi2_stat_acc csi2_stat_acc (
    .px_clk_i     ( px_clk_i       ),
    .reset_i      ( reset_i        ),
    .clear_stat_i ( clear_stat     ),
    .video_i      ( video_up_i     ),
    .tready_i     ( video_tready_i ),
    .err_i        ( err_i          ),
    .stat_o       ( stat           )
  );

  csi2_csr csi2_csr (
    .px_clk_i          ( px_clk_i          ),
    .reset_i           ( reset_i           ),
    .req_i             ( csr_req_i         ),
    .rsp_o             ( csr_rsp_o         ),
    .stat_i            ( stat              ),
    .clear_stat_o      ( clear_stat        ),
    .phy_en_o          ( phy_en_o          ),
    .delay_act_o       ( delay_act_o       ),
    .lane_delay_o      ( lane_delay_o      ),
    .sccb_slave_addr_o ( sccb_slave_addr_o )
  );

  // Sensor power-up sequencing
  cam_pwup cam_pwup (
    .px_clk_i   ( px_clk_i   ),
    .reset_i    ( reset_i    ),
    .cam_pwup_o ( cam_pwup_o )
  );

endmodule

`default_nettype wire

//--- dv/csi2_monitor_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_monitor_checker (
  input  logic                px_clk_i,
  input  logic                reset_i,
  input  csi2_pkg::axil_req_t csr_req_i,
  input  csi2_pkg::axil_rsp_t csr_rsp_i,
  input  logic                cam_pwup_i
);

  int err_cnt = 0;

  // Write response held until the manager takes it
  bvalid_held: assert property (@(posedge px_clk_i) disable iff (reset_i)
    csr_rsp_i.bvalid && !csr_req_i.bready |=> csr_rsp_i.bvalid)
    else begin
      $error("bvalid dropped before bready");
      err_cnt++;
    end

  rdata_stable: assert property (@(posedge px_clk_i) disable iff (reset_i)
    csr_rsp_i.rvalid && !csr_req_i.rready |=> csr_rsp_i.rvalid && $stable(csr_rsp_i.rdata))
    else begin
      $error("rvalid or rdata changed before rready");
      err_cnt++;
    end

  // Address and data are taken together
  awready_with_valid: assert property (@(posedge px_clk_i) disable iff (reset_i)
    csr_rsp_i.awready |-> csr_req_i.awvalid && csr_req_i.wvalid)
    else begin
      $error("awready high without awvalid and wvalid");
      err_cnt++;
    end

  pwup_sticky: assert property (@(posedge px_clk_i) disable iff (reset_i)
    cam_pwup_i |=> cam_pwup_i)
    else begin
      $error("cam_pwup_o fell after rising");
      err_cnt++;
    end

endmodule

bind csi2_monitor_top csi2_monitor_checker u_checker (
  .px_clk_i   ( px_clk_i   ),
  .reset_i    ( reset_i    ),
  .csr_req_i  ( csr_req_i  ),
  .csr_rsp_i  ( csr_rsp_o  ),
  .cam_pwup_i ( cam_pwup_o )
);

`default_nettype wire

//--- dv/csi2_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csi2_config.svh"

module csi2_monitor_tb;

  import csi2_pkg::*;

  // Generous bound over the whole test sequence
  localparam int WATCHDOG_CYCLES = 20000;

  logic                                          px_clk;
  logic                                          reset;
  axil_req_t                                     csr_req;
  axil_rsp_t                                     csr_rsp;
  video_t                                        video_up;
  logic                                          up_tready;
  video_t                                        video_dn;
  logic                                          video_tready;
  csi2_err_t                                     err;
  logic                                          phy_en;
  logic                                          delay_act;
  logic [`CSI2_LANES-1 : 0][`CSI2_DELAY_W-1 : 0] lane_delay;
  logic [6 : 0]                                  sccb_addr;
  logic                                          cam_pwup;

  integer seed = 19034;
  int     test_errs = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     act_pulses = 0;
  int     hdr_cnt = 0;
  int     corr_cnt = 0;
  int     crc_cnt = 0;

  // Expected stream statistics
  logic [31 : 0] exp_max_px;
  logic [31 : 0] exp_min_px;
  logic [31 : 0] exp_max_ln;
  logic [31 : 0] exp_min_ln;
  logic          frame_open;
  int            prev_lines;

  logic [31 : 0] rd_val;
  logic [1 : 0]  resp;

  csi2_monitor_top u_dut (
    .px_clk_i          ( px_clk       ),
    .reset_i           ( reset        ),
    .csr_req_i         ( csr_req      ),
    .csr_rsp_o         ( csr_rsp      ),
    .video_up_i        ( video_up     ),
    .up_tready_o       ( up_tready    ),
    .video_o           ( video_dn     ),
    .video_tready_i    ( video_tready ),
    .err_i             ( err          ),
    .phy_en_o          ( phy_en       ),
    .delay_act_o       ( delay_act    ),
    .lane_delay_o      ( lane_delay   ),
    .sccb_slave_addr_o ( sccb_addr    ),
    .cam_pwup_o        ( cam_pwup     )
  );

  initial begin
    px_clk = 1'b0;
    forever #5 px_clk = ~px_clk;
  end

  always @(negedge px_clk) begin
    if (delay_act)
      act_pulses++;
  end

  task automatic check_value(input string name, input logic [31 : 0] exp_val,
                             input logic [31 : 0] act_val);
    assert (act_val === exp_val) else begin
      $display("mismatch at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, exp_val, act_val);
      test_errs++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    test_errs++;
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %s: fail with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic axil_write(input logic [7 : 0] addr, input logic [31 : 0] data,
                            input logic [3 : 0] strb, output logic [1 : 0] bresp);
    int n;
    @(negedge px_clk);
    csr_req.awvalid = 1'b1;
    csr_req.wvalid  = 1'b1;
    csr_req.awaddr  = addr;
    csr_req.wdata   = data;
    csr_req.wstrb   = strb;
    n = 0;
    do begin
      @(negedge px_clk);
      n++;
    end while (!csr_rsp.awready && n < 32);
    if (!csr_rsp.awready)
      report_problem("write was never accepted");
    else
      check_value("wready", 1, csr_rsp.wready);
    // Past the accepting edge
    @(negedge px_clk);
    csr_req.awvalid = 1'b0;
    csr_req.wvalid  = 1'b0;
    n = 0;
    while (!csr_rsp.bvalid && n < 32) begin
      @(negedge px_clk);
      n++;
    end
    if (!csr_rsp.bvalid)
      report_problem("no write response");
    repeat ({$random(seed)} % 4) @(negedge px_clk);
    bresp = csr_rsp.bresp;
    csr_req.bready = 1'b1;
    @(negedge px_clk);
    csr_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7 : 0] addr, output logic [31 : 0] data,
                           output logic [1 : 0] rresp);
    int n;
    @(negedge px_clk);
    csr_req.arvalid = 1'b1;
    csr_req.araddr  = addr;
    n = 0;
    do begin
      @(negedge px_clk);
      n++;
    end while (!csr_rsp.arready && n < 32);
    if (!csr_rsp.arready)
      report_problem("read address was never accepted");
    @(negedge px_clk);
    csr_req.arvalid = 1'b0;
    n = 0;
    while (!csr_rsp.rvalid && n < 32) begin
      @(negedge px_clk);
      n++;
    end
    if (!csr_rsp.rvalid)
      report_problem("no read response");
    repeat ({$random(seed)} % 4) @(negedge px_clk);
    data  = csr_rsp.rdata;
    rresp = csr_rsp.rresp;
    csr_req.rready = 1'b1;
    @(negedge px_clk);
    csr_req.rready = 1'b0;
  endtask

  task automatic write_reg(input logic [7 : 0] addr, input logic [31 : 0] data,
                           input logic [3 : 0] strb);
    logic [1 : 0] bresp;
    axil_write(addr, data, strb, bresp);
    check_value("bresp", RESP_OKAY, bresp);
  endtask

  task automatic read_check(input string name, input logic [7 : 0] addr,
                            input logic [31 : 0] exp_val);
    logic [31 : 0] data;
    logic [1 : 0]  rresp;
    axil_read(addr, data, rresp);
    check_value(name, exp_val, data);
    check_value({name, " rresp"}, RESP_OKAY, rresp);
  endtask

  task automatic clear_model();
    exp_max_px = '0;
    exp_min_px = '1;
    exp_max_ln = '0;
    exp_min_ln = '1;
    frame_open = 1'b0;
  endtask

  // Line lengths packed as nibbles with the first line in bits 3..0
  task automatic send_frame(input int n_lines, input logic [31 : 0] lens);
    int l;
    int len;
    int sent;
    // Next tuser closes the previous frame
    if (frame_open) begin
      if (prev_lines > exp_max_ln)
        exp_max_ln = prev_lines;
      if (prev_lines < exp_min_ln)
        exp_min_ln = prev_lines;
    end
    frame_open = 1'b1;
    prev_lines = n_lines;
    for (l = 0; l < n_lines; l++) begin
      len  = lens[4*l +: 4];
      sent = 0;
      while (sent < len) begin
        @(negedge px_clk);
        check_value("video_o", video_up, video_dn);
        check_value("up_tready_o", video_tready, up_tready);
        video_up.tvalid = ({$random(seed)} % 4) != 0;
        video_up.tuser  = (l == 0) && (sent == 0);
        video_up.tlast  = (sent == len - 1);
        video_up.tdata  = `CSI2_PX_W'($random(seed));
        video_tready    = ({$random(seed)} % 3) != 0;
        if (video_up.tvalid && video_tready)
          sent++;
      end
      if (len > exp_max_px)
        exp_max_px = len;
      if (len < exp_min_px)
        exp_min_px = len;
    end
    @(negedge px_clk);
    video_up.tvalid = 1'b0;
    video_tready    = 1'b1;
  endtask

  task automatic check_stream_stats();
    read_check("max_ln_per_frame", REG_MAX_LN_PER_FRAME, exp_max_ln);
    read_check("min_ln_per_frame", REG_MIN_LN_PER_FRAME, exp_min_ln);
    read_check("max_px_per_ln", REG_MAX_PX_PER_LN, exp_max_px);
    read_check("min_px_per_ln", REG_MIN_PX_PER_LN, exp_min_px);
  endtask

  initial begin
    int k;
    csr_req      = '0;
    video_up     = '0;
    video_tready = 1'b1;
    err          = '0;
    reset        = 1'b1;
    clear_model();
    repeat (3) @(negedge px_clk);
    reset = 1'b0;

    check_value("phy_en_o", 0, phy_en);
    check_value("delay_act_o", 0, delay_act);
    check_value("lane_delay_o", 0, lane_delay);
    check_value("sccb_slave_addr_o", 0, sccb_addr);
    check_value("csr_rsp_o handshake", 0,
                {csr_rsp.awready, csr_rsp.wready, csr_rsp.bvalid,
                 csr_rsp.arready, csr_rsp.rvalid});
    for (k = 1; k <= `CSI2_PWUP_CYCLES + 4; k++) begin
      @(negedge px_clk);
      check_value("cam_pwup_o", k >= `CSI2_PWUP_CYCLES, cam_pwup);
    end
    end_test("reset_and_powerup");

    write_reg(REG_CTRL, 32'h1, 4'hf);
    check_value("phy_en_o", 1, phy_en);
    read_check("ctrl", REG_CTRL, 32'h1);
    write_reg(REG_SCCB_ADDR, 32'h42, 4'hf);
    check_value("sccb_slave_addr_o", 7'h42, sccb_addr);
    read_check("sccb_addr", REG_SCCB_ADDR, 32'h42);
    write_reg(REG_DELAY, 32'h1305, 4'hf);
    check_value("lane_delay_o", {5'h13, 5'h05}, lane_delay);
    write_reg(REG_DELAY, 32'h0a1f, 4'h1);
    check_value("lane_delay_o", {5'h13, 5'h1f}, lane_delay);
    read_check("delay", REG_DELAY, 32'h131f);
    write_reg(REG_SCCB_ADDR, 32'hff, 4'h2);
    write_reg(REG_CTRL, 32'h0, 4'h0);
    read_check("sccb_addr", REG_SCCB_ADDR, 32'h42);
    check_value("phy_en_o", 1, phy_en);
    act_pulses = 0;
    write_reg(REG_CTRL, 32'h5, 4'h1);
    repeat (2) @(negedge px_clk);
    check_value("delay_act_o pulses", 1, act_pulses);
    read_check("ctrl", REG_CTRL, 32'h1);
    end_test("control_registers");

    repeat (60) begin
      @(negedge px_clk);
      err.header_err      = ({$random(seed)} % 3) == 0;
      err.corr_header_err = ({$random(seed)} % 2) == 0;
      err.crc_err         = ({$random(seed)} % 5) == 0;
      hdr_cnt  += err.header_err;
      corr_cnt += err.corr_header_err;
      crc_cnt  += err.crc_err;
    end
    @(negedge px_clk);
    err = '0;
    read_check("header_err_cnt", REG_HDR_ERR_CNT, hdr_cnt);
    read_check("corr_header_err_cnt", REG_CORR_HDR_ERR_CNT, corr_cnt);
    read_check("crc_err_cnt", REG_CRC_ERR_CNT, crc_cnt);
    end_test("error_counters");

    send_frame(3, 32'h0000_0395);
    send_frame(5, 32'h0002_8647);
    send_frame(1, 32'h0000_0006);
    check_stream_stats();
    end_test("line_frame_stats");

    write_reg(REG_CTRL, 32'h3, 4'h1);
    clear_model();
    hdr_cnt  = 0;
    corr_cnt = 0;
    crc_cnt  = 0;
    read_check("header_err_cnt", REG_HDR_ERR_CNT, 0);
    read_check("corr_header_err_cnt", REG_CORR_HDR_ERR_CNT, 0);
    read_check("crc_err_cnt", REG_CRC_ERR_CNT, 0);
    check_stream_stats();
    send_frame(2, 32'h0000_0044);
    send_frame(1, 32'h0000_0003);
    check_stream_stats();
    end_test("clear_stats");

    axil_read(8'h0c, rd_val, resp);
    check_value("unmapped rresp", RESP_SLVERR, resp);
    check_value("unmapped rdata", 0, rd_val);
    axil_write(REG_HDR_ERR_CNT, 32'hdead_beef, 4'hf, resp);
    check_value("stat write bresp", RESP_SLVERR, resp);
    read_check("header_err_cnt", REG_HDR_ERR_CNT, hdr_cnt);
    end_test("error_responses");

    $display("summary: %0d passed, %0d failed, %0d assertion failures",
             pass_cnt, fail_cnt, u_dut.u_checker.err_cnt);
    if (fail_cnt == 0 && u_dut.u_checker.err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge px_clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/csi2_pkg.sv
verilog/csi2_stat_acc.sv
verilog/csi2_csr.sv
verilog/cam_pwup.sv
verilog/csi2_monitor_top.sv
dv/csi2_monitor_checker.sv
dv/csi2_monitor_tb.sv

//--- Bender.yml
package:
  name: csi2_monitor

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/csi2_pkg.sv
      - verilog/csi2_stat_acc.sv
      - verilog/csi2_csr.sv
      - verilog/cam_pwup.sv
      - verilog/csi2_monitor_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/csi2_monitor_checker.sv
      - dv/csi2_monitor_tb.sv
